// ==== verilog/depar_pkg.sv ====
package depar_pkg;

	localparam int data_width_def = 512;
	localparam int tuser_width_def = 128;
	localparam int phv_width_def = 1280;
	localparam int vlan_width = 12;

	// containers packed from the top of the phv, metadata underneath
	localparam int cont_count = 8;
	localparam int cont6_bits = 48;
	localparam int cont4_bits = 32;
	localparam int cont2_bits = 16;
	localparam int phv_discard_bit = 128;

	localparam int num_actions = 10;
	localparam int action_width = 16;
	localparam int entry_width = num_actions * action_width;
	localparam int table_depth = 32;
	localparam int table_addr_width = $clog2(table_depth);
	localparam int field_width = cont6_bits;

	localparam logic [15:0] ctrl_flag_value = 16'hf2f1;
	localparam int ctrl_modid_lsb = 368;
	localparam int ctrl_flag_lsb = 320;
	localparam int ctrl_index_lsb = 384;

	typedef enum logic [1:0] {
		field_none,
		field_bytes2,
		field_bytes4,
		field_bytes6
	} field_type_e;

	typedef enum logic [3:0] {
		st_idle,
		st_wait_ram,
		st_start,
		st_extract,
		st_patch,
		st_flush_first,
		st_flush_second,
		st_flush_tail,
		st_drop_head,
		st_drop_tail
	} depar_state_e;

	typedef enum logic [1:0] {
		ctrl_idle,
		ctrl_write_first,
		ctrl_write_next
	} ctrl_state_e;

endpackage

// ==== verilog/depar_ctrl_loader.sv ====
`timescale 1ns/1ps

module depar_ctrl_loader #(
	parameter int data_width = depar_pkg::data_width_def,
	parameter logic [2:0] deparser_mod_id = 3'b101
) (
	input  logic clk,
	input  logic aresetn,
	input  logic [data_width-1:0] ctrl_tdata,
	input  logic ctrl_tvalid,
	input  logic ctrl_tlast,
	output logic tbl_wr_en,
	output logic [depar_pkg::table_addr_width-1:0] tbl_wr_addr,
	output logic [depar_pkg::entry_width-1:0] tbl_wr_data
);

	depar_pkg::ctrl_state_e state;
	logic [data_width-1:0] tdata_swapped;
	logic hdr_match;

	// control payload arrives little endian
	always_comb begin
		for (int i = 0; i < data_width/8; i++) begin
			tdata_swapped[data_width-1-8*i -: 8] = ctrl_tdata[8*i +: 8];
		end
	end

	assign hdr_match = (ctrl_tdata[depar_pkg::ctrl_modid_lsb +: 3] == deparser_mod_id) &&
		(ctrl_tdata[depar_pkg::ctrl_flag_lsb +: 16] == depar_pkg::ctrl_flag_value);

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= depar_pkg::ctrl_idle;
			tbl_wr_en <= 1'b0;
			tbl_wr_addr <= '0;
		end else begin
			tbl_wr_en <= 1'b0;
			case (state)
				depar_pkg::ctrl_idle: begin
					if (ctrl_tvalid && hdr_match) begin
						tbl_wr_addr <= ctrl_tdata[depar_pkg::ctrl_index_lsb +:
							depar_pkg::table_addr_width];
						state <= depar_pkg::ctrl_write_first;
					end
				end
				default: begin
					if (ctrl_tvalid) begin
						tbl_wr_en <= 1'b1;
						if (state == depar_pkg::ctrl_write_next) begin
							tbl_wr_addr <= tbl_wr_addr + 1'b1; // consecutive entries
						end
						state <= ctrl_tlast ? depar_pkg::ctrl_idle : depar_pkg::ctrl_write_next;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_tvalid) begin
			tbl_wr_data <= tdata_swapped[data_width-1 -: depar_pkg::entry_width];
		end
	end

	// a header beat seen in idle must not itself reach the table
	assert property (@(posedge clk) disable iff (!aresetn)
		state == depar_pkg::ctrl_idle |=> !tbl_wr_en)
		else $error("table write issued from idle");

endmodule

// ==== verilog/parse_act_table.sv ====
`timescale 1ns/1ps

module parse_act_table (
	input  logic clk,
	input  logic tbl_wr_en,
	input  logic [depar_pkg::table_addr_width-1:0] tbl_wr_addr,
	input  logic [depar_pkg::entry_width-1:0] tbl_wr_data,
	input  logic [depar_pkg::vlan_width-1:0] vlan_id,
	output logic [depar_pkg::entry_width-1:0] act_entry
);

	logic [depar_pkg::entry_width-1:0] mem [depar_pkg::table_depth];

	// all entries start out with no valid action
	initial begin
		for (int i = 0; i < depar_pkg::table_depth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (tbl_wr_en) begin
			mem[tbl_wr_addr] <= tbl_wr_data;
		end
		act_entry <= mem[vlan_id[4 +: depar_pkg::table_addr_width]]; // vlan bits 8:4
	end

endmodule

// ==== verilog/field_extract.sv ====
`timescale 1ns/1ps

module field_extract #(
	parameter int phv_width = depar_pkg::phv_width_def
) (
	input  logic clk,
	input  logic aresetn,
	input  logic extract_start,
	input  logic [depar_pkg::action_width-1:0] action,
	input  logic [phv_width-1:0] phv,
	output logic [depar_pkg::field_width-1:0] field_value,
	output depar_pkg::field_type_e field_type
);

	localparam int w6 = depar_pkg::cont6_bits;
	localparam int w4 = depar_pkg::cont4_bits;
	localparam int w2 = depar_pkg::cont2_bits;
	localparam int top4 = phv_width - depar_pkg::cont_count * w6;
	localparam int top2 = top4 - depar_pkg::cont_count * w4;

	depar_pkg::field_type_e act_type;
	logic [2:0] cont_num;
	logic [depar_pkg::field_width-1:0] raw;
	logic [depar_pkg::field_width-1:0] swapped;

	assign act_type = depar_pkg::field_type_e'(action[2:1]);
	assign cont_num = action[5:3];

	// left aligned, so the swap drops the field into the low bytes
	always_comb begin
		case (act_type)
			depar_pkg::field_bytes2: raw = {phv[top2 - w2*(cont_num+1) +: w2], 32'h0};
			depar_pkg::field_bytes4: raw = {phv[top4 - w4*(cont_num+1) +: w4], 16'h0};
			depar_pkg::field_bytes6: raw = phv[phv_width - w6*(cont_num+1) +: w6];
			default: raw = '0;
		endcase
		for (int i = 0; i < w6/8; i++) begin
			swapped[8*i +: 8] = raw[w6-8-8*i +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (extract_start) begin
			field_value <= swapped;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			field_type <= depar_pkg::field_none;
		end else if (extract_start) begin
			field_type <= action[0] ? act_type : depar_pkg::field_none;
		end
	end

endmodule

// ==== verilog/beat_patcher.sv ====
`timescale 1ns/1ps

module beat_patcher #(
	parameter int data_width = depar_pkg::data_width_def,
	parameter int tuser_width = depar_pkg::tuser_width_def
) (
	input  logic clk,
	input  logic aresetn,
	input  logic head_load,
	input  logic patch_apply,
	input  logic [data_width-1:0] fst_half_tdata,
	input  logic [data_width/8-1:0] fst_half_tkeep,
	input  logic fst_half_tlast,
	input  logic [data_width-1:0] snd_half_tdata,
	input  logic [data_width/8-1:0] snd_half_tkeep,
	input  logic [tuser_width-1:0] snd_half_tuser,
	input  logic snd_half_tlast,
	input  logic [tuser_width-1:0] phv_user,
	input  logic [depar_pkg::entry_width-1:0] act_entry,
	input  logic [depar_pkg::num_actions-1:0][depar_pkg::field_width-1:0] field_value,
	input  depar_pkg::field_type_e [depar_pkg::num_actions-1:0] field_type,
	output logic [data_width-1:0] beat1_tdata,
	output logic [data_width/8-1:0] beat1_tkeep,
	output logic [tuser_width-1:0] beat1_tuser,
	output logic beat1_tlast,
	output logic [data_width-1:0] beat2_tdata,
	output logic [data_width/8-1:0] beat2_tkeep,
	output logic [tuser_width-1:0] beat2_tuser,
	output logic beat2_tlast
);

	localparam int beat_bytes = data_width / 8;

	logic [data_width-1:0] patched1;
	logic [data_width-1:0] patched2;

	// later actions overwrite earlier ones
	always_comb begin
		logic [depar_pkg::action_width-1:0] act;
		int off;
		int len;
		patched1 = beat1_tdata;
		patched2 = beat2_tdata;
		for (int i = 0; i < depar_pkg::num_actions; i++) begin
			act = act_entry[depar_pkg::entry_width - depar_pkg::action_width*(i+1) +:
				depar_pkg::action_width];
			off = act[12:6];
			case (field_type[i])
				depar_pkg::field_bytes2: len = 2;
				depar_pkg::field_bytes4: len = 4;
				depar_pkg::field_bytes6: len = 6;
				default: len = 0;
			endcase
			if (len != 0 && off + len <= beat_bytes) begin // skip fields past the beat end
				for (int b = 0; b < depar_pkg::field_width/8; b++) begin
					if (b < len && i < depar_pkg::num_actions/2) begin
						patched1[8*(off+b) +: 8] = field_value[i][8*b +: 8];
					end else if (b < len) begin
						patched2[8*(off+b) +: 8] = field_value[i][8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (head_load) begin
			beat1_tdata <= fst_half_tdata;
			beat1_tuser <= phv_user; // tuser replaced by low phv bits
			beat2_tdata <= snd_half_tdata;
			beat2_tuser <= snd_half_tuser;
		end else if (patch_apply) begin
			beat1_tdata <= patched1;
			beat2_tdata <= patched2;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			beat1_tkeep <= '0;
			beat1_tlast <= 1'b0;
			beat2_tkeep <= '0;
			beat2_tlast <= 1'b0;
		end else if (head_load) begin
			beat1_tkeep <= fst_half_tkeep;
			beat1_tlast <= fst_half_tlast;
			beat2_tkeep <= snd_half_tkeep;
			beat2_tlast <= snd_half_tlast;
		end
	end

endmodule

// ==== verilog/depar_flow_ctrl.sv ====
`timescale 1ns/1ps

module depar_flow_ctrl #(
	parameter int data_width = depar_pkg::data_width_def,
	parameter int tuser_width = depar_pkg::tuser_width_def
) (
	input  logic clk,
	input  logic aresetn,
	input  logic vlan_empty,
	input  logic phv_empty,
	input  logic fst_half_empty,
	input  logic fst_half_tlast,
	input  logic snd_half_empty,
	input  logic snd_half_tlast,
	input  logic pkt_empty,
	input  logic [data_width-1:0] pkt_tdata,
	input  logic [data_width/8-1:0] pkt_tkeep,
	input  logic [tuser_width-1:0] pkt_tuser,
	input  logic pkt_tlast,
	input  logic phv_discard,
	input  logic [data_width-1:0] beat1_tdata,
	input  logic [data_width/8-1:0] beat1_tkeep,
	input  logic [tuser_width-1:0] beat1_tuser,
	input  logic beat1_tlast,
	input  logic [data_width-1:0] beat2_tdata,
	input  logic [data_width/8-1:0] beat2_tkeep,
	input  logic [tuser_width-1:0] beat2_tuser,
	input  logic beat2_tlast,
	input  logic out_tready,
	output logic vlan_rd_en,
	output logic phv_rd_en,
	output logic fst_half_rd_en,
	output logic snd_half_rd_en,
	output logic pkt_rd_en,
	output logic extract_start,
	output logic head_load,
	output logic patch_apply,
	output logic [data_width-1:0] out_tdata,
	output logic [data_width/8-1:0] out_tkeep,
	output logic [tuser_width-1:0] out_tuser,
	output logic out_tlast,
	output logic out_tvalid
);

	depar_pkg::depar_state_e state;
	depar_pkg::depar_state_e state_next;

	always_comb begin
		state_next = state;
		vlan_rd_en = 1'b0;
		phv_rd_en = 1'b0;
		fst_half_rd_en = 1'b0;
		snd_half_rd_en = 1'b0;
		pkt_rd_en = 1'b0;
		extract_start = 1'b0;
		head_load = 1'b0;
		patch_apply = 1'b0;
		out_tdata = '0;
		out_tkeep = '0;
		out_tuser = '0;
		out_tlast = 1'b0;
		out_tvalid = 1'b0;
		case (state)
			depar_pkg::st_idle: begin
				if (!vlan_empty) begin
					state_next = depar_pkg::st_wait_ram;
				end
			end
			depar_pkg::st_wait_ram: state_next = depar_pkg::st_start; // table read in flight
			depar_pkg::st_start: begin
				if (!fst_half_empty && !snd_half_empty && !phv_empty) begin
					if (phv_discard) begin
						phv_rd_en = 1'b1;
						state_next = depar_pkg::st_drop_head;
					end else begin
						head_load = 1'b1;
						extract_start = 1'b1;
						state_next = depar_pkg::st_extract;
					end
				end
			end
			depar_pkg::st_extract: state_next = depar_pkg::st_patch; // fields registering
			depar_pkg::st_patch: begin
				patch_apply = 1'b1;
				state_next = depar_pkg::st_flush_first;
			end
			depar_pkg::st_flush_first: begin
				out_tdata = beat1_tdata;
				out_tkeep = beat1_tkeep;
				out_tuser = beat1_tuser;
				out_tlast = beat1_tlast;
				if (out_tready) begin
					out_tvalid = 1'b1;
					vlan_rd_en = 1'b1;
					phv_rd_en = 1'b1;
					fst_half_rd_en = 1'b1;
					snd_half_rd_en = 1'b1; // popped even for one-beat packets
					state_next = beat1_tlast ? depar_pkg::st_idle : depar_pkg::st_flush_second;
				end
			end
			depar_pkg::st_flush_second: begin
				out_tdata = beat2_tdata;
				out_tkeep = beat2_tkeep;
				out_tuser = beat2_tuser;
				out_tlast = beat2_tlast;
				if (out_tready) begin
					out_tvalid = 1'b1;
					state_next = beat2_tlast ? depar_pkg::st_idle : depar_pkg::st_flush_tail;
				end
			end
			depar_pkg::st_flush_tail: begin
				if (!pkt_empty) begin
					out_tdata = pkt_tdata;
					out_tkeep = pkt_tkeep;
					out_tuser = pkt_tuser;
					out_tlast = pkt_tlast;
					if (out_tready) begin
						out_tvalid = 1'b1;
						pkt_rd_en = 1'b1;
						state_next = pkt_tlast ? depar_pkg::st_idle : depar_pkg::st_flush_tail;
					end
				end
			end
			depar_pkg::st_drop_head: begin
				vlan_rd_en = 1'b1;
				fst_half_rd_en = 1'b1;
				snd_half_rd_en = 1'b1;
				if (fst_half_tlast || snd_half_tlast) begin
					state_next = depar_pkg::st_idle;
				end else begin
					state_next = depar_pkg::st_drop_tail;
				end
			end
			depar_pkg::st_drop_tail: begin
				if (!pkt_empty) begin
					pkt_rd_en = 1'b1;
					state_next = pkt_tlast ? depar_pkg::st_idle : depar_pkg::st_drop_tail;
				end
			end
			default: state_next = depar_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= depar_pkg::st_idle;
		end else begin
			state <= state_next;
		end
	end

	// the fwft fifos upstream cannot take a pop while empty
	assert property (@(posedge clk) disable iff (!aresetn)
		!((vlan_rd_en && vlan_empty) || (phv_rd_en && phv_empty) ||
		(fst_half_rd_en && fst_half_empty) || (snd_half_rd_en && snd_half_empty) ||
		(pkt_rd_en && pkt_empty)))
		else $error("fifo read while empty");

	// extracted fields are registered one cycle before the patch uses them
	assert property (@(posedge clk) disable iff (!aresetn) extract_start |=> ##1 patch_apply)
		else $error("patch not applied two cycles after extract");

endmodule

// ==== verilog/depar_top.sv ====
`timescale 1ns/1ps

module depar_top #(
	parameter int data_width = depar_pkg::data_width_def,
	parameter int tuser_width = depar_pkg::tuser_width_def,
	parameter int phv_width = depar_pkg::phv_width_def,
	parameter logic [2:0] deparser_mod_id = 3'b101
) (
	input  logic clk,
	input  logic aresetn,
	input  logic [depar_pkg::vlan_width-1:0] vlan_id,
	input  logic vlan_empty,
	output logic vlan_rd_en,
	input  logic [phv_width-1:0] phv,
	input  logic phv_empty,
	output logic phv_rd_en,
	input  logic [data_width-1:0] fst_half_tdata,
	input  logic [data_width/8-1:0] fst_half_tkeep,
	input  logic fst_half_tlast,
	input  logic fst_half_empty,
	output logic fst_half_rd_en,
	input  logic [data_width-1:0] snd_half_tdata,
	input  logic [data_width/8-1:0] snd_half_tkeep,
	input  logic [tuser_width-1:0] snd_half_tuser,
	input  logic snd_half_tlast,
	input  logic snd_half_empty,
	output logic snd_half_rd_en,
	input  logic [data_width-1:0] pkt_tdata,
	input  logic [data_width/8-1:0] pkt_tkeep,
	input  logic [tuser_width-1:0] pkt_tuser,
	input  logic pkt_tlast,
	input  logic pkt_empty,
	output logic pkt_rd_en,
	input  logic [data_width-1:0] ctrl_tdata,
	input  logic ctrl_tvalid,
	input  logic ctrl_tlast,
	output logic [data_width-1:0] out_tdata,
	output logic [data_width/8-1:0] out_tkeep,
	output logic [tuser_width-1:0] out_tuser,
	output logic out_tlast,
	output logic out_tvalid,
	input  logic out_tready
);

	logic tbl_wr_en;
	logic [depar_pkg::table_addr_width-1:0] tbl_wr_addr;
	logic [depar_pkg::entry_width-1:0] tbl_wr_data;
	logic [depar_pkg::entry_width-1:0] act_entry;
	logic extract_start;
	logic head_load;
	logic patch_apply;
	logic phv_discard;
	logic [depar_pkg::num_actions-1:0][depar_pkg::field_width-1:0] field_value;
	depar_pkg::field_type_e [depar_pkg::num_actions-1:0] field_type;
	logic [data_width-1:0] beat1_tdata;
	logic [data_width/8-1:0] beat1_tkeep;
	logic [tuser_width-1:0] beat1_tuser;
	logic beat1_tlast;
	logic [data_width-1:0] beat2_tdata;
	logic [data_width/8-1:0] beat2_tkeep;
	logic [tuser_width-1:0] beat2_tuser;
	logic beat2_tlast;

	assign phv_discard = phv[depar_pkg::phv_discard_bit];

	depar_ctrl_loader #(
		.data_width(data_width),
		.deparser_mod_id(deparser_mod_id)
	) u_loader (.*);

	parse_act_table u_table (.*);

	// action 0 sits in the top bits of the entry
	for (genvar i = 0; i < depar_pkg::num_actions; i++) begin : g_extract
		field_extract #(
			.phv_width(phv_width)
		) u_extract (
			.clk(clk),
			.aresetn(aresetn),
			.extract_start(extract_start),
			.action(act_entry[depar_pkg::entry_width - depar_pkg::action_width*(i+1) +:
				depar_pkg::action_width]),
			.phv(phv),
			.field_value(field_value[i]),
			.field_type(field_type[i])
		);
	end

	beat_patcher #(
		.data_width(data_width),
		.tuser_width(tuser_width)
	) u_patcher (
		.phv_user(phv[tuser_width-1:0]),
		.*
	);

	depar_flow_ctrl #(
		.data_width(data_width),
		.tuser_width(tuser_width)
	) u_flow (.*);

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int period = 20,
	parameter int reset_cycles = 10
) (
	output logic clk,
	output logic aresetn
);

	initial begin
		clk = 1'b0;
		forever #(period/2) clk = ~clk;
	end

	// released on a falling edge, away from the flops
	initial begin
		aresetn = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;
	end

endmodule

// ==== testbench/depar_tb.sv ====
`timescale 1ns/1ps

module depar_tb;

	localparam int bw = 705; // {last, user, keep, data}

	typedef struct packed {
		logic [1:0] load_mode; // 0 none, 1 load, 2 bad module id, 3 bad flag
		logic [4:0] load_idx;
		logic [1:0] entry_sel;
		logic [1:0] load_count;
		logic [11:0] vlan;
		logic [3:0] beats;
		logic discard;
		logic rand_ready;
	} test_row_t;

	logic clk;
	logic aresetn;
	logic [11:0] vlan_id;
	logic vlan_empty;
	logic vlan_rd_en;
	logic [1279:0] phv;
	logic phv_empty;
	logic phv_rd_en;
	logic [511:0] fst_half_tdata;
	logic [63:0] fst_half_tkeep;
	logic fst_half_tlast;
	logic fst_half_empty;
	logic fst_half_rd_en;
	logic [511:0] snd_half_tdata;
	logic [63:0] snd_half_tkeep;
	logic [127:0] snd_half_tuser;
	logic snd_half_tlast;
	logic snd_half_empty;
	logic snd_half_rd_en;
	logic [511:0] pkt_tdata;
	logic [63:0] pkt_tkeep;
	logic [127:0] pkt_tuser;
	logic pkt_tlast;
	logic pkt_empty;
	logic pkt_rd_en;
	logic [511:0] ctrl_tdata;
	logic ctrl_tvalid;
	logic ctrl_tlast;
	logic [511:0] out_tdata;
	logic [63:0] out_tkeep;
	logic [127:0] out_tuser;
	logic out_tlast;
	logic out_tvalid;
	logic out_tready;

	logic [11:0] vlan_q [$];
	logic [1279:0] phv_q [$];
	logic [576:0] fst_q [$];
	logic [bw-1:0] snd_q [$];
	logic [bw-1:0] pkt_q [$];
	logic [bw-1:0] got_q [$];

	logic [159:0] entries [4];
	logic [159:0] shadow [32]; // expected table contents
	test_row_t rows [12];
	integer seed;
	logic rand_ready;
	int error_count;
	int pass_count;
	int fail_count;
	logic timed_out;

	tb_clk_gen #(.period(20), .reset_cycles(10)) u_clk_gen (.clk(clk), .aresetn(aresetn));

	depar_top #(.deparser_mod_id(3'b101)) UUT (.*);

	function automatic logic [15:0] make_action(input logic v, input logic [1:0] typ,
		input logic [2:0] num, input logic [6:0] off);
		return {3'b000, off, num, typ, v};
	endfunction

	// phv bytes counted from the top: 6-byte containers, then 4-byte, then 2-byte
	function automatic logic [511:0] insert_fields(input logic [511:0] beat,
		input logic [159:0] entry, input logic [1279:0] phv_word, input int first);
		logic [15:0] act;
		int len;
		int start;
		int off;
		logic [511:0] res;
		res = beat;
		for (int a = first; a < first + 5; a++) begin
			act = entry[159 - 16*a -: 16];
			off = int'(act[12:6]);
			case (act[2:1])
				2'd1: begin len = 2; start = 80 + 2*int'(act[5:3]); end
				2'd2: begin len = 4; start = 48 + 4*int'(act[5:3]); end
				2'd3: begin len = 6; start = 6*int'(act[5:3]); end
				default: begin len = 0; start = 0; end
			endcase
			if (act[0] && len > 0 && off + len <= 64) begin
				for (int b = 0; b < len; b++) begin
					res[8*(off+b) +: 8] = phv_word[1279 - 8*(start+b) -: 8];
				end
			end
		end
		return res;
	endfunction

	task automatic place_action(input int sel, input int a, input logic [15:0] act);
		entries[sel][159 - 16*a -: 16] = act;
	endtask

	task automatic build_entries();
		for (int s = 0; s < 4; s++) begin
			entries[s] = '0;
		end
		place_action(1, 0, make_action(1'b1, 2'd1, 3'd3, 7'd0));
		place_action(1, 1, make_action(1'b1, 2'd2, 3'd1, 7'd10));
		place_action(1, 2, make_action(1'b1, 2'd3, 3'd0, 7'd12)); // overlaps action 1
		place_action(1, 3, make_action(1'b0, 2'd3, 3'd4, 7'd30));
		place_action(1, 4, make_action(1'b1, 2'd3, 3'd7, 7'd58)); // ends on the last byte
		place_action(1, 5, make_action(1'b1, 2'd3, 3'd2, 7'd0));
		place_action(1, 6, make_action(1'b1, 2'd1, 3'd7, 7'd63)); // runs past the end
		place_action(1, 7, make_action(1'b1, 2'd2, 3'd5, 7'd20));
		place_action(1, 8, make_action(1'b1, 2'd1, 3'd0, 7'd22));
		place_action(1, 9, make_action(1'b1, 2'd2, 3'd7, 7'd60));
		place_action(2, 0, make_action(1'b1, 2'd3, 3'd5, 7'd3));
		place_action(2, 2, make_action(1'b1, 2'd2, 3'd2, 7'd40));
		place_action(2, 6, make_action(1'b1, 2'd1, 3'd4, 7'd5));
		place_action(2, 9, make_action(1'b1, 2'd3, 3'd1, 7'd100));
		place_action(3, 1, make_action(1'b1, 2'd1, 3'd1, 7'd1));
		place_action(3, 4, make_action(1'b1, 2'd2, 3'd6, 7'd33));
		place_action(3, 5, make_action(1'b1, 2'd3, 3'd3, 7'd7));
		place_action(3, 8, make_action(1'b1, 2'd2, 3'd0, 7'd50));
	endtask

	task automatic random_word(output logic [1279:0] v);
		for (int i = 0; i < 40; i++) begin
			v[32*i +: 32] = $random(seed);
		end
	endtask

	task automatic report_empty_pop(input string name);
		$display("read strobe on the empty %s FIFO at %0t", name, $time);
		error_count++;
	endtask

	task automatic send_ctrl(input test_row_t r);
		logic [511:0] word;
		logic [159:0] entry;
		word = '0;
		word[368 +: 3] = (r.load_mode == 2'd2) ? 3'b010 : 3'b101;
		word[320 +: 16] = (r.load_mode == 2'd3) ? 16'hf2f0 : 16'hf2f1;
		word[384 +: 5] = r.load_idx;
		@(negedge clk);
		ctrl_tdata = word;
		ctrl_tvalid = 1'b1;
		ctrl_tlast = 1'b0;
		for (int k = 0; k < int'(r.load_count); k++) begin
			entry = entries[int'(r.entry_sel) + k];
			word = '0;
			for (int n = 0; n < 20; n++) begin
				word[8*n +: 8] = entry[159 - 8*n -: 8]; // entry msb byte first on the wire
			end
			@(negedge clk);
			ctrl_tdata = word;
			ctrl_tlast = (k == int'(r.load_count) - 1);
			if (r.load_mode == 2'd1) begin
				shadow[int'(r.load_idx) + k] = entry;
			end
		end
		@(negedge clk);
		ctrl_tvalid = 1'b0;
		ctrl_tlast = 1'b0;
		ctrl_tdata = '0;
		repeat (2) @(posedge clk);
	endtask

	task automatic run_test(input int t);
		test_row_t r;
		logic [159:0] entry;
		logic [1279:0] phv_word;
		logic [1279:0] rnd;
		logic [63:0] keep;
		logic last;
		logic [bw-1:0] exp_q [$];
		int errs;
		int cnt;
		r = rows[t];
		errs = 0;
		if (r.load_mode != 2'd0) begin
			send_ctrl(r);
		end
		entry = shadow[r.vlan[8:4]];
		random_word(phv_word);
		phv_word[128] = r.discard;
		rand_ready = r.rand_ready;
		vlan_q.push_back(r.vlan);
		phv_q.push_back(phv_word);
		for (int b = 0; b < int'(r.beats); b++) begin
			random_word(rnd);
			last = (b == int'(r.beats) - 1);
			keep = last ? ({64{1'b1}} >> rnd[1029:1024]) : {64{1'b1}};
			if (b == 0) begin
				fst_q.push_back({last, keep, rnd[511:0]});
				exp_q.push_back({last, phv_word[127:0], keep,
					insert_fields(rnd[511:0], entry, phv_word, 0)});
			end else if (b == 1) begin
				snd_q.push_back({last, rnd[1279:1152], keep, rnd[511:0]});
				exp_q.push_back({last, rnd[1279:1152], keep,
					insert_fields(rnd[511:0], entry, phv_word, 5)});
			end else begin
				pkt_q.push_back({last, rnd[1279:1152], keep, rnd[511:0]});
				exp_q.push_back({last, rnd[1279:1152], keep, rnd[511:0]});
			end
		end
		if (r.beats == 4'd1) begin
			random_word(rnd);
			snd_q.push_back({1'b0, rnd[1279:1152], {64{1'b1}}, rnd[511:0]}); // unused half
		end
		if (r.discard) begin
			exp_q.delete();
		end
		cnt = 0;
		while (cnt < 1000 && !(vlan_q.size() == 0 && phv_q.size() == 0 && fst_q.size() == 0 &&
			snd_q.size() == 0 && pkt_q.size() == 0 && got_q.size() >= exp_q.size())) begin
			@(posedge clk);
			cnt++;
		end
		if (cnt >= 1000) begin
			$display("test %0d: timed out waiting for the packet to leave the FIFOs", t);
			timed_out = 1'b1;
			errs++;
		end
		if (got_q.size() != exp_q.size()) begin
			$display("ERROR at %0t: test %0d got %0d beats, expected %0d", $time, t,
				got_q.size(), exp_q.size());
			errs++;
		end
		for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
			if (got_q[i][511:0] !== exp_q[i][511:0]) begin
				$display("ERROR at %0t: test %0d beat %0d tdata mismatch", $time, t, i);
				errs++;
			end
			if (got_q[i][575:512] !== exp_q[i][575:512]) begin
				$display("ERROR at %0t: test %0d beat %0d tkeep %h, expected %h", $time, t, i,
					got_q[i][575:512], exp_q[i][575:512]);
				errs++;
			end
			if (got_q[i][703:576] !== exp_q[i][703:576]) begin
				$display("ERROR at %0t: test %0d beat %0d tuser %h, expected %h", $time, t, i,
					got_q[i][703:576], exp_q[i][703:576]);
				errs++;
			end
			if (got_q[i][704] !== exp_q[i][704]) begin
				$display("ERROR at %0t: test %0d beat %0d tlast %b, expected %b", $time, t, i,
					got_q[i][704], exp_q[i][704]);
				errs++;
			end
		end
		got_q.delete();
		error_count += errs;
		if (errs == 0) pass_count++;
		else fail_count++;
		$display("test %0d vlan %h beats %0d discard %0b random ready %0b: %s", t, r.vlan,
			r.beats, r.discard, r.rand_ready, (errs == 0) ? "pass" : "FAIL");
	endtask

	// fwft fifo heads and tready change on the falling edge, strobes sampled mid low phase
	initial begin
		vlan_id = '0;
		vlan_empty = 1'b1;
		phv = '0;
		phv_empty = 1'b1;
		{fst_half_tlast, fst_half_tkeep, fst_half_tdata} = '0;
		fst_half_empty = 1'b1;
		{snd_half_tlast, snd_half_tuser, snd_half_tkeep, snd_half_tdata} = '0;
		snd_half_empty = 1'b1;
		{pkt_tlast, pkt_tuser, pkt_tkeep, pkt_tdata} = '0;
		pkt_empty = 1'b1;
		out_tready = 1'b0;
		forever begin
			@(negedge clk);
			vlan_empty = (vlan_q.size() == 0);
			vlan_id = vlan_empty ? '0 : vlan_q[0];
			phv_empty = (phv_q.size() == 0);
			phv = phv_empty ? '0 : phv_q[0];
			fst_half_empty = (fst_q.size() == 0);
			{fst_half_tlast, fst_half_tkeep, fst_half_tdata} = fst_half_empty ? '0 : fst_q[0];
			snd_half_empty = (snd_q.size() == 0);
			{snd_half_tlast, snd_half_tuser, snd_half_tkeep, snd_half_tdata} =
				snd_half_empty ? '0 : snd_q[0];
			pkt_empty = (pkt_q.size() == 0);
			{pkt_tlast, pkt_tuser, pkt_tkeep, pkt_tdata} = pkt_empty ? '0 : pkt_q[0];
			out_tready = rand_ready ? 1'($random(seed)) : 1'b1;
			#5;
			if (out_tvalid) got_q.push_back({out_tlast, out_tuser, out_tkeep, out_tdata});
			if (vlan_rd_en) begin
				if (vlan_q.size() == 0) report_empty_pop("vlan");
				else void'(vlan_q.pop_front());
			end
			if (phv_rd_en) begin
				if (phv_q.size() == 0) report_empty_pop("phv");
				else void'(phv_q.pop_front());
			end
			if (fst_half_rd_en) begin
				if (fst_q.size() == 0) report_empty_pop("first half");
				else void'(fst_q.pop_front());
			end
			if (snd_half_rd_en) begin
				if (snd_q.size() == 0) report_empty_pop("second half");
				else void'(snd_q.pop_front());
			end
			if (pkt_rd_en) begin
				if (pkt_q.size() == 0) report_empty_pop("packet");
				else void'(pkt_q.pop_front());
			end
		end
	end

	initial begin
		int cnt;
		ctrl_tdata = '0;
		ctrl_tvalid = 1'b0;
		ctrl_tlast = 1'b0;
		rand_ready = 1'b0;
		seed = 32'h2b0f_8ffb;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		build_entries();
		// mode, index, entry, count, vlan, beats, discard, random ready
		rows[0] = '{2'd0, 5'd0, 2'd0, 2'd0, 12'h000, 4'd3, 1'b0, 1'b0};
		rows[1] = '{2'd1, 5'd5, 2'd1, 2'd1, 12'h050, 4'd4, 1'b0, 1'b0};
		rows[2] = '{2'd0, 5'd0, 2'd0, 2'd0, 12'he5f, 4'd1, 1'b0, 1'b0};
		rows[3] = '{2'd0, 5'd0, 2'd0, 2'd0, 12'h050, 4'd3, 1'b1, 1'b0};
		rows[4] = '{2'd0, 5'd0, 2'd0, 2'd0, 12'h050, 4'd2, 1'b0, 1'b0};
		rows[5] = '{2'd2, 5'd5, 2'd2, 2'd1, 12'h050, 4'd2, 1'b0, 1'b0};
		rows[6] = '{2'd3, 5'd5, 2'd2, 2'd1, 12'h055, 4'd3, 1'b0, 1'b0};
		rows[7] = '{2'd1, 5'd9, 2'd2, 2'd2, 12'h090, 4'd3, 1'b0, 1'b0};
		rows[8] = '{2'd0, 5'd0, 2'd0, 2'd0, 12'h0a3, 4'd5, 1'b0, 1'b1};
		rows[9] = '{2'd0, 5'd0, 2'd0, 2'd0, 12'h050, 4'd6, 1'b0, 1'b1};
		rows[10] = '{2'd0, 5'd0, 2'd0, 2'd0, 12'h090, 4'd1, 1'b1, 1'b1};
		rows[11] = '{2'd0, 5'd0, 2'd0, 2'd0, 12'h100, 4'd2, 1'b0, 1'b1};
		cnt = 0;
		while (!aresetn && cnt < 50) begin
			@(posedge clk);
			cnt++;
		end
		if (!aresetn) begin
			$display("reset was never released");
			timed_out = 1'b1;
		end
		for (int t = 0; t < 12; t++) begin
			if (!timed_out) run_test(t);
		end
		$display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count,
			error_count);
		if (error_count == 0 && fail_count == 0 && !timed_out) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== depar_top.f ====
verilog/depar_pkg.sv
verilog/depar_ctrl_loader.sv
verilog/parse_act_table.sv
verilog/field_extract.sv
verilog/beat_patcher.sv
verilog/depar_flow_ctrl.sv
verilog/depar_top.sv
testbench/tb_clk_gen.sv
testbench/depar_tb.sv
